//--- umi_cmd.f
rtl/umi_pkg.sv
rtl/umi_if.sv
rtl/umi_decode.sv
rtl/umi_pack.sv
rtl/umi_unpack.sv
rtl/umi_cmd_loop.sv
tb/umi_cmd_loop_chk.sv
tb/tb_umi_cmd_loop.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UMI command loop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f umi_cmd.f --top-module tb_umi_cmd_loop -o sim_umi_cmd

# The simulator status is not trusted, the log decides
./obj_dir/sim_umi_cmd > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

//--- tb/tb_umi_cmd_loop.sv
// UMI command loop testbench, random commands checked against a field-sharing model
`timescale 1ns/1ns
`default_nettype none

module tb_umi_cmd_loop;

   localparam int CW         = 32;
   localparam int RST_CYC    = 3;
   localparam int NUM_TESTS  = 500;                        // First 32 sweep every opcode
   localparam int TIMEOUT_NS = (RST_CYC + NUM_TESTS + 10) * 10;

   localparam int C_REQ  = 6;   // Class vector bit order
   localparam int C_RSP  = 5;
   localparam int C_ATOM = 4;
   localparam int C_ERR  = 3;
   localparam int C_LINK = 2;
   localparam int C_LRSP = 1;
   localparam int C_INV  = 0;

   typedef logic [umi_pkg::UMI_USER_W-1:0] field_val_t;   // Widest field

   typedef struct packed {
      logic [umi_pkg::UMI_OPCODE_W-1:0] opcode;
      logic [umi_pkg::UMI_SIZE_W-1:0]   size;
      logic [umi_pkg::UMI_LEN_W-1:0]    len;
      logic [umi_pkg::UMI_ATYPE_W-1:0]  atype;
      logic [umi_pkg::UMI_PROT_W-1:0]   prot;
      logic [umi_pkg::UMI_QOS_W-1:0]    qos;
      logic                             eom;
      logic                             eof;
      logic                             ex;
      logic [umi_pkg::UMI_USER_W-1:0]   user;
      logic [umi_pkg::UMI_ERR_W-1:0]    err;
      logic [umi_pkg::UMI_HOSTID_W-1:0] hostid;
   } cmd_fields_t;

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   in_valid;
   cmd_fields_t            drv;         // DUT field inputs
   cmd_fields_t            got;         // DUT field outputs
   logic                   out_valid;
   logic [CW-1:0]          packet;
   logic [6:0]             got_cls;     // DUT class outputs
   umi_pkg::umi_cmd_word_t exp_words[$];
   cmd_fields_t            exp_fields[$];
   umi_pkg::umi_cmd_word_t last_word;   // Word an idle cycle must hold
   integer                 seed = 11;
   int                     checks, word_errs, field_errs, class_errs;

   always #5 clk = ~clk;

   umi_cmd_loop #(.CW(CW)) DUT (
      .clk (clk), .rst (rst), .in_valid (in_valid),
      .in_opcode (drv.opcode), .in_size (drv.size), .in_len (drv.len), .in_atype (drv.atype),
      .in_prot (drv.prot), .in_qos (drv.qos), .in_eom (drv.eom), .in_eof (drv.eof),
      .in_ex (drv.ex), .in_user (drv.user), .in_err (drv.err), .in_hostid (drv.hostid),
      .out_valid (out_valid), .packet (packet),
      .out_opcode (got.opcode), .out_size (got.size), .out_len (got.len),
      .out_atype (got.atype), .out_prot (got.prot), .out_qos (got.qos), .out_eom (got.eom),
      .out_eof (got.eof), .out_ex (got.ex), .out_user (got.user), .out_err (got.err),
      .out_hostid (got.hostid),
      .out_request (got_cls[C_REQ]), .out_response (got_cls[C_RSP]),
      .out_atomic (got_cls[C_ATOM]), .out_error (got_cls[C_ERR]), .out_link (got_cls[C_LINK]),
      .out_link_resp (got_cls[C_LRSP]), .out_invalid (got_cls[C_INV])
   );

   bind umi_cmd_loop umi_cmd_loop_chk #(.CW(CW)) u_chk (
      .clk (clk), .rst (rst), .in_valid (in_valid), .out_valid (out_valid), .packet (packet),
      .out_request (out_request), .out_response (out_response), .out_error (out_error),
      .out_invalid (out_invalid)
   );

   // Odd up to 15 request, even 2..14 response, 16 error, rest invalid
   function automatic logic [6:0] class_of(input logic [umi_pkg::UMI_OPCODE_W-1:0] op);
      logic req, rsp, err_c;
      req   = op[0] && (op <= 5'd15);
      rsp   = !op[0] && (op != 5'd0) && (op <= 5'd14);
      err_c = (op == umi_pkg::UMI_ERROR);
      return {req, rsp, op == umi_pkg::UMI_REQ_ATOMIC, err_c, op == umi_pkg::UMI_REQ_LINK,
              op == umi_pkg::UMI_RESP_LINK, !(req || rsp || err_c)};
   endfunction

   function automatic umi_pkg::umi_cmd_word_t expected_word(input cmd_fields_t f);
      umi_pkg::umi_cmd_word_t w;
      logic [6:0]             c;
      c = class_of(f.opcode);
      w = '0;
      w.std.hostid = f.hostid;
      w.std.opcode = f.opcode;
      if (c[C_LINK] | c[C_LRSP]) begin                     // User spread over the header
         w.std.size   = c[C_LINK] ? 3'd1 : 3'd0;
         w.std.lenfld = f.user[7:0];
         w.std.qos    = f.user[11:8];
         w.std.prot   = f.user[13:12];
         w.std.flags  = f.user[16:14];
         w.std.ue     = c[C_LINK] ? f.user[18:17] : f.err;
      end else begin
         w.std.size   = c[C_ERR] ? 3'd0 : f.size;
         w.std.lenfld = c[C_ATOM] ? f.atype : (c[C_ERR] ? f.user[7:0] : f.len);
         w.std.qos    = f.qos;
         w.std.prot   = f.prot;
         w.std.flags  = c[C_ERR] ? f.user[10:8] : {f.ex, f.eof, f.eom};
         w.std.ue     = (c[C_RSP] | c[C_ERR]) ? f.err : f.user[1:0];
      end
      return w;
   endfunction

   // What survives the trip, fields without a slot come back zero
   function automatic cmd_fields_t expected_fields(input cmd_fields_t f);
      cmd_fields_t e;
      logic [6:0]  c;
      logic        lnk;
      c   = class_of(f.opcode);
      lnk = c[C_LINK] | c[C_LRSP];
      e   = '0;
      e.opcode = f.opcode;
      e.hostid = f.hostid;
      if (c[C_LINK]) e.user = f.user;
      else if (c[C_LRSP]) e.user[16:0] = f.user[16:0];  // Top pair went to err
      else if (c[C_ERR]) e.user[10:0] = f.user[10:0];
      else if (!c[C_RSP]) e.user[1:0] = f.user[1:0];
      if (c[C_RSP] | c[C_ERR]) e.err = f.err;
      if (!lnk) begin
         e.prot = f.prot;
         e.qos  = f.qos;
      end
      if (!lnk && !c[C_ERR]) begin
         e.size = f.size;
         {e.ex, e.eof, e.eom} = {f.ex, f.eof, f.eom};
         if (c[C_ATOM]) e.atype = f.atype;
         else e.len = f.len;
      end
      return e;
   endfunction

   task automatic check_word(input umi_pkg::umi_cmd_word_t got_w,
                             input umi_pkg::umi_cmd_word_t exp_w);
      checks++;
      if (got_w !== exp_w) begin
         word_errs++;
         $display("Error at %0t: packet %h, expected %h (opcode %0d)",
                  $time, got_w, exp_w, exp_w.std.opcode);
      end
   endtask

   task automatic check_field(input string name, input field_val_t got_v, input field_val_t exp_v);
      checks++;
      if (got_v !== exp_v) begin
         field_errs++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, got_v, exp_v);
      end
   endtask

   task automatic check_class(input logic [6:0] got_c, input logic [6:0] exp_c,
                              input logic [umi_pkg::UMI_OPCODE_W-1:0] op);
      checks++;
      if (got_c !== exp_c) begin
         class_errs++;
         $display("Error at %0t: class flags %b, expected %b for opcode %0d",
                  $time, got_c, exp_c, op);
      end
   endtask

   task automatic compare_fields(input cmd_fields_t exp_f);
      check_field("opcode", field_val_t'(got.opcode), field_val_t'(exp_f.opcode));
      check_field("size",   field_val_t'(got.size),   field_val_t'(exp_f.size));
      check_field("len",    field_val_t'(got.len),    field_val_t'(exp_f.len));
      check_field("atype",  field_val_t'(got.atype),  field_val_t'(exp_f.atype));
      check_field("prot",   field_val_t'(got.prot),   field_val_t'(exp_f.prot));
      check_field("qos",    field_val_t'(got.qos),    field_val_t'(exp_f.qos));
      check_field("eom",    field_val_t'(got.eom),    field_val_t'(exp_f.eom));
      check_field("eof",    field_val_t'(got.eof),    field_val_t'(exp_f.eof));
      check_field("ex",     field_val_t'(got.ex),     field_val_t'(exp_f.ex));
      check_field("user",   got.user,                 exp_f.user);
      check_field("err",    field_val_t'(got.err),    field_val_t'(exp_f.err));
      check_field("hostid", field_val_t'(got.hostid), field_val_t'(exp_f.hostid));
   endtask

   // Random fields, opcode swept first then drawn from all 32 codes
   task automatic drive_command(input int idx);
      logic [31:0] r;
      r = $random(seed);
      drv.user   = r[18:0];
      drv.hostid = r[23:19];
      drv.qos    = r[27:24];
      drv.prot   = r[29:28];
      drv.err    = r[31:30];
      r = $random(seed);
      drv.len    = r[7:0];
      drv.atype  = r[15:8];
      drv.size   = r[18:16];
      {drv.ex, drv.eof, drv.eom} = r[21:19];
      drv.opcode = r[26:22];
      in_valid   = (r[28:27] != 2'b00);                 // About one idle cycle in four
      if (idx < 32) begin
         drv.opcode = idx[4:0];
         in_valid   = 1'b1;
      end
      if (in_valid) begin
         exp_words.push_back(expected_word(drv));
         exp_fields.push_back(expected_fields(drv));
      end
   endtask

   // in_valid still holds the value driven a cycle ago
   task automatic sample_outputs();
      umi_pkg::umi_cmd_word_t ew;
      check_field("out_valid", field_val_t'(out_valid), field_val_t'(in_valid));
      if (in_valid) begin
         ew = exp_words.pop_front();
         check_word(packet, ew);
         compare_fields(exp_fields.pop_front());
         check_class(got_cls, class_of(ew.std.opcode), ew.std.opcode);
         last_word = ew;
      end else begin
         check_word(packet, last_word);                 // Idle holds the word
      end
   endtask

   initial begin
      int i;
      rst       = 1'b1;
      in_valid  = 1'b0;
      drv       = '0;
      last_word = '0;
      repeat (RST_CYC) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_field("out_valid", field_val_t'(out_valid), '0);  // Reset state
      check_word(packet, '0);
      for (i = 0; i < NUM_TESTS; i++) begin
         drive_command(i);
         @(negedge clk);
         sample_outputs();
      end
      in_valid = 1'b0;
      @(negedge clk);
      sample_outputs();
      $display("Checks %0d, word errors %0d, field errors %0d, class errors %0d",
               checks, word_errs, field_errs, class_errs);
      if (word_errs + field_errs + class_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/umi_cmd_loop_chk.sv
// UMI command loop checker with register timing and class output assertions
`timescale 1ns/1ns
`default_nettype none

module umi_cmd_loop_chk #(
   parameter int CW = 32
) (
   input wire logic          clk,
   input wire logic          rst,
   input wire logic          in_valid,
   input wire logic          out_valid,
   input wire logic [CW-1:0] packet,
   input wire logic          out_request,
   input wire logic          out_response,
   input wire logic          out_error,
   input wire logic          out_invalid
);

   // Register comes out of reset empty
   a_reset_clear: assert property (@(posedge clk) rst |=> !out_valid)
      else $error("out_valid high in the cycle after reset");

   // One cycle of latency and no stall
   a_valid_follow: assert property (@(posedge clk) disable iff (rst)
      !$past(rst) |-> (out_valid == $past(in_valid)))
      else $error("out_valid does not follow in_valid of the previous cycle");

   // Idle cycle keeps the last word
   a_word_hold: assert property (@(posedge clk) disable iff (rst)
      (!$past(rst) && !out_valid) |-> $stable(packet))
      else $error("packet changed while out_valid low");

   // One group per word, odd up to 15 request, 16 error, 0 and above 16 invalid
   a_one_group: assert property (@(posedge clk) disable iff (rst)
      $onehot({out_request, out_response, out_error, out_invalid}) &&
      (out_request == (packet[0] && (packet[4:0] <= 5'd15))) &&
      (out_error == (packet[4:0] == 5'd16)) &&
      (out_invalid == ((packet[4:0] == 5'd0) || (packet[4:0] > 5'd16))))
      else $error("class group flags do not match the opcode of the word");

endmodule

`default_nettype wire

//--- rtl/umi_cmd_loop.sv
// UMI command loop, packs fields, registers the word, then unpacks and classifies it
`timescale 1ns/1ns
`default_nettype none

module umi_cmd_loop #(
   parameter int CW = 32
) (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             in_valid,
   // Command fields in
   input  wire logic [umi_pkg::UMI_OPCODE_W-1:0] in_opcode,
   input  wire logic [umi_pkg::UMI_SIZE_W-1:0]   in_size,
   input  wire logic [umi_pkg::UMI_LEN_W-1:0]    in_len,
   input  wire logic [umi_pkg::UMI_ATYPE_W-1:0]  in_atype,
   input  wire logic [umi_pkg::UMI_PROT_W-1:0]   in_prot,
   input  wire logic [umi_pkg::UMI_QOS_W-1:0]    in_qos,
   input  wire logic                             in_eom,
   input  wire logic                             in_eof,
   input  wire logic                             in_ex,
   input  wire logic [umi_pkg::UMI_USER_W-1:0]   in_user,
   input  wire logic [umi_pkg::UMI_ERR_W-1:0]    in_err,
   input  wire logic [umi_pkg::UMI_HOSTID_W-1:0] in_hostid,
   // Registered word
   output      logic                             out_valid,
   output      logic [CW-1:0]                    packet,
   // Unpacked fields
   output      logic [umi_pkg::UMI_OPCODE_W-1:0] out_opcode,
   output      logic [umi_pkg::UMI_SIZE_W-1:0]   out_size,
   output      logic [umi_pkg::UMI_LEN_W-1:0]    out_len,
   output      logic [umi_pkg::UMI_ATYPE_W-1:0]  out_atype,
   output      logic [umi_pkg::UMI_PROT_W-1:0]   out_prot,
   output      logic [umi_pkg::UMI_QOS_W-1:0]    out_qos,
   output      logic                             out_eom,
   output      logic                             out_eof,
   output      logic                             out_ex,
   output      logic [umi_pkg::UMI_USER_W-1:0]   out_user,
   output      logic [umi_pkg::UMI_ERR_W-1:0]    out_err,
   output      logic [umi_pkg::UMI_HOSTID_W-1:0] out_hostid,
   // Class of the registered word
   output      logic                             out_request,
   output      logic                             out_response,
   output      logic                             out_atomic,
   output      logic                             out_error,
   output      logic                             out_link,
   output      logic                             out_link_resp,
   output      logic                             out_invalid
);

   umi_cmd_if   in_if ();    // Fields into packer
   umi_cmd_if   out_if ();   // Fields from unpacker
   umi_class_if out_cls ();  // Class of registered word

   logic [CW-1:0] packed_word;  // Combinational pack result

   assign in_if.opcode = in_opcode;
   assign in_if.size   = in_size;
   assign in_if.len    = in_len;
   assign in_if.atype  = in_atype;
   assign in_if.prot   = in_prot;
   assign in_if.qos    = in_qos;
   assign in_if.eom    = in_eom;
   assign in_if.eof    = in_eof;
   assign in_if.ex     = in_ex;
   assign in_if.user   = in_user;
   assign in_if.err    = in_err;
   assign in_if.hostid = in_hostid;

   umi_pack #(.CW(CW)) u_pack (
      .fields (in_if.dst),
      .packet (packed_word)
   );

   // One-stage register, word holds when idle
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
         packet    <= '0;
      end else begin
         out_valid <= in_valid;
         if (in_valid) begin
            packet <= packed_word;
         end
      end
   end

   umi_unpack #(.CW(CW)) u_unpack (
      .packet (packet),
      .fields (out_if.src),
      .cls    (out_cls.dec)
   );

   assign out_opcode    = out_if.opcode;
   assign out_size      = out_if.size;
   assign out_len       = out_if.len;
   assign out_atype     = out_if.atype;
   assign out_prot      = out_if.prot;
   assign out_qos       = out_if.qos;
   assign out_eom       = out_if.eom;
   assign out_eof       = out_if.eof;
   assign out_ex        = out_if.ex;
   assign out_user      = out_if.user;
   assign out_err       = out_if.err;
   assign out_hostid    = out_if.hostid;

   assign out_request   = out_cls.request;
   assign out_response  = out_cls.response;
   assign out_atomic    = out_cls.atomic;
   assign out_error     = out_cls.error;
   assign out_link      = out_cls.link;
   assign out_link_resp = out_cls.link_resp;
   assign out_invalid   = out_cls.invalid;

endmodule

`default_nettype wire

//--- rtl/umi_unpack.sv
// UMI command unpacker, recovers fields and class from a header word
`timescale 1ns/1ns
`default_nettype none

module umi_unpack #(
   parameter int CW = 32
) (
   input  wire logic [CW-1:0] packet,
   umi_cmd_if.src             fields,
   umi_class_if.dec           cls
);

   umi_pkg::umi_cmd_word_t word;
   logic                   lnk_any;  // link or link_resp

   assign word = packet[umi_pkg::UMI_CMD_W-1:0];  // Bits above the header ignored

   // Decoder drives the class port directly
   umi_decode #(.CW(CW)) u_decode (
      .opcode (word.std.opcode),
      .cls    (cls)
   );

   assign lnk_any = cls.link | cls.link_resp;

   // Always present
   assign fields.opcode = word.std.opcode;
   assign fields.hostid = word.std.hostid;

   // Size has no slot for link, link_resp or error
   assign fields.size  = (lnk_any | cls.error) ? '0 : word.std.size;

   // Shared len slot
   assign fields.len   = (lnk_any | cls.error | cls.atomic) ? '0 : word.std.lenfld;
   assign fields.atype = cls.atomic ? word.std.lenfld : '0;

   // qos and prot lost to user bits on link classes
   assign fields.prot  = lnk_any ? '0 : word.std.prot;
   assign fields.qos   = lnk_any ? '0 : word.std.qos;

   // Flag bits, {ex,eof,eom}
   assign fields.ex  = (lnk_any | cls.error) ? 1'b0 : word.std.flags[2];
   assign fields.eof = (lnk_any | cls.error) ? 1'b0 : word.std.flags[1];
   assign fields.eom = (lnk_any | cls.error) ? 1'b0 : word.std.flags[0];

   // ue slot holds err on any response, link_resp included
   assign fields.err = (cls.response | cls.error) ? word.std.ue : '0;

   always_comb begin
      if (cls.link) begin
         fields.user = word.link.payload;                      // Full 19 bits
      end else if (cls.link_resp) begin
         fields.user = {2'b00, word.link.payload[16:0]};       // Top pair is err
      end else if (cls.error) begin
         fields.user = {8'h00, word.std.flags, word.std.lenfld}; // user[10:0]
      end else if (cls.response) begin
         fields.user = '0;                                     // ue taken by err
      end else begin
         fields.user = {17'h0_0000, word.std.ue};              // Requests, invalid
      end
   end

endmodule

`default_nettype wire

//--- rtl/umi_pack.sv
// UMI command packer, folds the command fields into one header word
`timescale 1ns/1ns
`default_nettype none

module umi_pack #(
   parameter int CW = 32
) (
   umi_cmd_if.dst             fields,
   output     logic [CW-1:0]  packet
);

   umi_class_if          cls ();     // Local decode of the field opcode
   umi_pkg::umi_cmd_word_t word;

   umi_decode #(.CW(CW)) u_decode (
      .opcode (fields.opcode),
      .cls    (cls.dec)
   );

   always_comb begin
      word = '0;
      if (cls.link | cls.link_resp) begin
         // Link view, user spread over the whole middle
         word.link.hostid  = fields.hostid;
         word.link.payload = cls.link ? fields.user                   // ue slot = user[18:17]
                                      : {fields.err, fields.user[16:0]}; // ue slot = err
         word.link.size    = cls.link ? 3'd1 : 3'd0;                  // Fixed size code
         word.link.opcode  = fields.opcode;
      end else begin
         word.std.hostid = fields.hostid;
         word.std.ue     = (cls.response | cls.error) ? fields.err
                                                      : fields.user[1:0];
         word.std.flags  = cls.error ? fields.user[10:8]
                                     : {fields.ex, fields.eof, fields.eom};
         word.std.prot   = fields.prot;
         word.std.qos    = fields.qos;
         if (cls.atomic) begin
            word.std.lenfld = fields.atype;         // Atomic reuses len slot
         end else if (cls.error) begin
            word.std.lenfld = fields.user[7:0];     // Error info in low user
         end else begin
            word.std.lenfld = fields.len;
         end
         word.std.size   = cls.error ? 3'd0 : fields.size;
         word.std.opcode = fields.opcode;
      end
   end

   // Upper bits zero on wide buses
   always_comb begin
      packet = '0;
      packet[umi_pkg::UMI_CMD_W-1:0] = word;
   end

endmodule

`default_nettype wire

//--- rtl/umi_decode.sv
// UMI command decoder, sorts an opcode into its request, response or error class
`timescale 1ns/1ns
`default_nettype none

module umi_decode #(
   parameter int CW = 32
) (
   input  wire logic [umi_pkg::UMI_OPCODE_W-1:0] opcode,
   umi_class_if.dec                              cls
);

   logic resp_read;
   logic resp_write;
   logic resp_user0;
   logic resp_user1;
   logic resp_future0;
   logic resp_future1;

   // Word narrower than the header layout cannot carry a command
   if (CW < umi_pkg::UMI_CMD_W) begin : g_cw_chk
      $error("umi_decode: CW smaller than command word");
   end

   // Request opcodes
   assign cls.read         = (opcode == umi_pkg::UMI_REQ_READ);
   assign cls.write        = (opcode == umi_pkg::UMI_REQ_WRITE);
   assign cls.write_posted = (opcode == umi_pkg::UMI_REQ_WRITE_POSTED);
   assign cls.rdma         = (opcode == umi_pkg::UMI_REQ_RDMA);
   assign cls.atomic       = (opcode == umi_pkg::UMI_REQ_ATOMIC);
   assign cls.user0        = (opcode == umi_pkg::UMI_REQ_USER0);
   assign cls.future0      = (opcode == umi_pkg::UMI_REQ_FUTURE0);
   assign cls.link         = (opcode == umi_pkg::UMI_REQ_LINK);

   // Response opcodes, only link_resp gets its own flag
   assign resp_read        = (opcode == umi_pkg::UMI_RESP_READ);
   assign resp_write       = (opcode == umi_pkg::UMI_RESP_WRITE);
   assign resp_user0       = (opcode == umi_pkg::UMI_RESP_USER0);
   assign resp_user1       = (opcode == umi_pkg::UMI_RESP_USER1);
   assign resp_future0     = (opcode == umi_pkg::UMI_RESP_FUTURE0);
   assign resp_future1     = (opcode == umi_pkg::UMI_RESP_FUTURE1);
   assign cls.link_resp    = (opcode == umi_pkg::UMI_RESP_LINK);

   assign cls.error        = (opcode == umi_pkg::UMI_ERROR);

   // Group flags
   assign cls.request  = cls.read | cls.write | cls.write_posted | cls.rdma |
                         cls.atomic | cls.user0 | cls.future0 | cls.link;
   assign cls.response = resp_read | resp_write | resp_user0 | resp_user1 |
                         resp_future0 | resp_future1 | cls.link_resp;

   // Opcode 0 and anything past ERROR
   assign cls.invalid  = ~(cls.request | cls.response | cls.error);

   // Even opcodes 2..14 map to kind 1..7
   assign cls.response_kind = cls.response ? opcode[3:1] : '0;

endmodule

`default_nettype wire

//--- rtl/umi_if.sv
// UMI interfaces for command fields and opcode class flags
`timescale 1ns/1ns
`default_nettype none

interface umi_cmd_if;
   logic [umi_pkg::UMI_OPCODE_W-1:0] opcode;
   logic [umi_pkg::UMI_SIZE_W-1:0]   size;
   logic [umi_pkg::UMI_LEN_W-1:0]    len;
   logic [umi_pkg::UMI_ATYPE_W-1:0]  atype;   // Atomic subtype passed through
   logic [umi_pkg::UMI_PROT_W-1:0]   prot;
   logic [umi_pkg::UMI_QOS_W-1:0]    qos;
   logic                             eom;
   logic                             eof;
   logic                             ex;
   logic [umi_pkg::UMI_USER_W-1:0]   user;
   logic [umi_pkg::UMI_ERR_W-1:0]    err;
   logic [umi_pkg::UMI_HOSTID_W-1:0] hostid;

   modport src (output opcode, size, len, atype, prot, qos, eom, eof, ex, user, err, hostid);
   modport dst (input  opcode, size, len, atype, prot, qos, eom, eof, ex, user, err, hostid);
endinterface

interface umi_class_if;
   logic                            invalid;
   logic                            request;      // Group flag
   logic                            response;     // Group flag
   logic                            read;
   logic                            write;
   logic                            write_posted;
   logic                            rdma;
   logic                            atomic;
   logic                            user0;
   logic                            future0;
   logic                            error;
   logic                            link;
   logic                            link_resp;
   logic [umi_pkg::UMI_RKIND_W-1:0] response_kind; // 0 when not a response

   modport dec  (output invalid, request, response, read, write, write_posted, rdma,
                 atomic, user0, future0, error, link, link_resp, response_kind);
   modport sink (input  invalid, request, response, read, write, write_posted, rdma,
                 atomic, user0, future0, error, link, link_resp, response_kind);
endinterface

`default_nettype wire

//--- rtl/umi_pkg.sv
// UMI command word package with field widths, opcode table and the two-view command word
`default_nettype none

package umi_pkg;

   // Field widths
   localparam int UMI_OPCODE_W = 5;
   localparam int UMI_SIZE_W   = 3;
   localparam int UMI_LEN_W    = 8;
   localparam int UMI_ATYPE_W  = 8;
   localparam int UMI_PROT_W   = 2;
   localparam int UMI_QOS_W    = 4;
   localparam int UMI_USER_W   = 19;
   localparam int UMI_ERR_W    = 2;
   localparam int UMI_HOSTID_W = 5;

   localparam int UMI_CMD_W    = 32;          // Command word width
   localparam int UMI_RKIND_W  = 3;           // Response kind index width

   // Requests sit on odd opcodes
   localparam logic [UMI_OPCODE_W-1:0] UMI_REQ_READ         = 5'd1;
   localparam logic [UMI_OPCODE_W-1:0] UMI_REQ_WRITE        = 5'd3;
   localparam logic [UMI_OPCODE_W-1:0] UMI_REQ_WRITE_POSTED = 5'd5;
   localparam logic [UMI_OPCODE_W-1:0] UMI_REQ_RDMA         = 5'd7;
   localparam logic [UMI_OPCODE_W-1:0] UMI_REQ_ATOMIC       = 5'd9;
   localparam logic [UMI_OPCODE_W-1:0] UMI_REQ_USER0        = 5'd11;
   localparam logic [UMI_OPCODE_W-1:0] UMI_REQ_FUTURE0      = 5'd13;
   localparam logic [UMI_OPCODE_W-1:0] UMI_REQ_LINK         = 5'd15;

   // Responses on nonzero even opcodes
   localparam logic [UMI_OPCODE_W-1:0] UMI_RESP_READ        = 5'd2;
   localparam logic [UMI_OPCODE_W-1:0] UMI_RESP_WRITE       = 5'd4;
   localparam logic [UMI_OPCODE_W-1:0] UMI_RESP_USER0       = 5'd6;
   localparam logic [UMI_OPCODE_W-1:0] UMI_RESP_USER1       = 5'd8;
   localparam logic [UMI_OPCODE_W-1:0] UMI_RESP_FUTURE0     = 5'd10;
   localparam logic [UMI_OPCODE_W-1:0] UMI_RESP_FUTURE1     = 5'd12;
   localparam logic [UMI_OPCODE_W-1:0] UMI_RESP_LINK        = 5'd14;

   localparam logic [UMI_OPCODE_W-1:0] UMI_ERROR            = 5'd16;  // Above this is invalid

   // Standard layout, header bits shared by len/atype/user
   typedef struct packed {
      logic [UMI_HOSTID_W-1:0] hostid;      // [31:27]
      logic [1:0]              ue;          // [26:25] err or user[1:0]
      logic [2:0]              flags;       // [24:22] {ex,eof,eom}
      logic [UMI_PROT_W-1:0]   prot;        // [21:20]
      logic [UMI_QOS_W-1:0]    qos;         // [19:16]
      logic [7:0]              lenfld;      // [15:8] len, atype or user
      logic [UMI_SIZE_W-1:0]   size;        // [7:5]
      logic [UMI_OPCODE_W-1:0] opcode;      // [4:0]
   } umi_cmd_std_t;

   // Link layout, middle bits are one user payload
   typedef struct packed {
      logic [UMI_HOSTID_W-1:0] hostid;      // [31:27]
      logic [18:0]             payload;     // [26:8]
      logic [UMI_SIZE_W-1:0]   size;        // [7:5] fixed code
      logic [UMI_OPCODE_W-1:0] opcode;      // [4:0]
   } umi_cmd_link_t;

   // Same 32 bits, read either way
   typedef union packed {
      umi_cmd_std_t  std;
      umi_cmd_link_t link;
   } umi_cmd_word_t;

endpackage

`default_nettype wire
